// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbAluStation
FLAGS     ?= --binary --timing --assert
MDIR      ?= obj_dir
FILELIST  ?= all.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: build
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)

// File: all.f
rsPkg.sv
wakeupMux.sv
rsEntry.sv
rsControl.sv
aluUnit.sv
aluStation.sv
tbClock.sv
tbAluStation.sv

// File: aluStation.sv
`timescale 1ns/1ps

module aluStation import rsPkg::*; #(
    parameter int rsSize = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  dispatch_t         dispatch,
    input  cdb_t              lsResult,
    output cdb_t              aluResult,
    output logic [rsSize-1:0] freeMask,
    output logic              stationFree
);

    logic   [rsSize-1:0] alloc;
    logic   [rsSize-1:0] occupied;
    logic   [rsSize-1:0] ready;
    issue_t [rsSize-1:0] candidates;
    issue_t              issue;

    // ======================================================================
    // Station slots
    // ======================================================================
    for (genvar i = 0; i < rsSize; i++) begin : gEntry
        rsEntry u_entry (
            .clk       (clk),
            .rst       (rst),
            .aluBus    (aluResult), // Own result fed back.
            .lsBus     (lsResult),
            .alloc     (alloc[i]),
            .dispatch  (dispatch),
            .occupied  (occupied[i]),
            .ready     (ready[i]),
            .candidate (candidates[i])
        );
    end

    // ======================================================================
    // Control and execution
    // ======================================================================
    rsControl #(
        .rsSize (rsSize)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .ready       (ready),
        .candidates  (candidates),
        .alloc       (alloc),
        .occupied    (occupied),
        .freeMask    (freeMask),
        .stationFree (stationFree),
        .issue       (issue)
    );

    aluUnit u_alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .result (aluResult)
    );

endmodule

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit import rsPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    output cdb_t   result
);

    localparam int shiftWidth = $clog2(dataWidth);

    logic [dataWidth-1:0]  value;
    logic [shiftWidth-1:0] shamt;

    assign shamt = issue.value1[shiftWidth-1:0]; // Low bits only.

    always_comb begin
        case (issue.op)
            opAdd:   value = issue.value0 + issue.value1;
            opSub:   value = issue.value0 - issue.value1;
            opAnd:   value = issue.value0 & issue.value1;
            opOr:    value = issue.value0 | issue.value1;
            opXor:   value = issue.value0 ^ issue.value1;
            opSll:   value = issue.value0 << shamt;
            opSrl:   value = issue.value0 >> shamt;
            opSlt:   value = dataWidth'($signed(issue.value0) < $signed(issue.value1));
            default: value = '0;
        endcase
    end

    // ======================================================================
    // Result broadcast
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid            <= issue.valid;
            result.tag.field.unit   <= unitAlu;
            result.tag.field.slot   <= issue.destTag.field.slot;
            result.name             <= issue.destName;
            result.data             <= value;
        end
    end

endmodule

// File: rsControl.sv
`timescale 1ns/1ps

module rsControl import rsPkg::*; #(
    parameter int rsSize = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  dispatch_t              dispatch,
    input  logic      [rsSize-1:0] ready,
    input  issue_t    [rsSize-1:0] candidates,
    output logic      [rsSize-1:0] alloc,
    output logic      [rsSize-1:0] occupied,
    output logic      [rsSize-1:0] freeMask,
    output logic                   stationFree,
    output issue_t                 issue
);

    localparam int countWidth = $clog2(rsSize + 1);

    logic [rsSize-1:0]     occupiedQ;
    logic [rsSize-1:0]     occupiedNext;
    logic [rsSize-1:0]     grant;
    logic [countWidth-1:0] freeCount;
    issue_t                picked;

    // ======================================================================
    // Allocation
    // ======================================================================

    // Slot comes straight from the destination tag.
    always_comb begin
        for (int i = 0; i < rsSize; i++) begin
            alloc[i] = dispatch.valid && (dispatch.destTag.field.slot == slotWidth'(i));
        end
    end

    // Empty slots left once this cycle's dispatch is counted.
    always_comb begin
        freeCount = '0;
        for (int i = 0; i < rsSize; i++) begin
            freeCount = freeCount + countWidth'(!(occupiedQ[i] || alloc[i]));
        end
    end

    assign stationFree = freeCount >= countWidth'(2);
    assign freeMask    = ~occupiedQ;
    assign occupied    = occupiedQ;

    // ======================================================================
    // Selection
    // ======================================================================

    // Lowest set ready bit.
    assign grant = ready & (~ready + rsSize'(1));

    always_comb begin
        picked = '0; // Idle issue, op is opNop.
        for (int i = 0; i < rsSize; i++) begin
            if (grant[i]) begin
                picked = candidates[i];
            end
        end
    end

    // A slot issued this cycle is free again after the edge.
    assign occupiedNext = (occupiedQ | alloc) & ~grant;

    // ======================================================================
    // Issue register
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupiedQ <= '0;
            issue     <= '0;
        end else begin
            occupiedQ <= occupiedNext;
            issue     <= picked;
        end
    end

endmodule

// File: rsEntry.sv
`timescale 1ns/1ps

module rsEntry import rsPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cdb_t      aluBus,
    input  cdb_t      lsBus,
    input  logic      alloc,
    input  dispatch_t dispatch,
    input  logic      occupied,
    output logic      ready,
    output issue_t    candidate
);

    rsTag_t               heldTag0;
    rsTag_t               heldTag1;
    logic [dataWidth-1:0] heldData0;
    logic [dataWidth-1:0] heldData1;
    aluOp_e               heldOp;
    rsTag_t               heldDestTag;
    logic [nameWidth-1:0] heldName;

    operand_t heldNext0;
    operand_t heldNext1;
    operand_t inNext0;
    operand_t inNext1;

    // ======================================================================
    // Wakeup of held and incoming operands
    // ======================================================================
    wakeupMux u_held0 (
        .aluBus (aluBus),
        .lsBus  (lsBus),
        .now    ('{tag: heldTag0, data: heldData0}),
        .next   (heldNext0)
    );

    wakeupMux u_held1 (
        .aluBus (aluBus),
        .lsBus  (lsBus),
        .now    ('{tag: heldTag1, data: heldData1}),
        .next   (heldNext1)
    );

    // A broadcast in the dispatch cycle itself is caught here.
    wakeupMux u_in0 (
        .aluBus (aluBus),
        .lsBus  (lsBus),
        .now    (dispatch.operand0),
        .next   (inNext0)
    );

    wakeupMux u_in1 (
        .aluBus (aluBus),
        .lsBus  (lsBus),
        .now    (dispatch.operand1),
        .next   (inNext1)
    );

    // ======================================================================
    // Slot storage
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            heldTag0.raw <= tagFree;
            heldTag1.raw <= tagFree;
        end else if (alloc) begin
            heldTag0 <= inNext0.tag;
            heldTag1 <= inNext1.tag;
        end else begin
            heldTag0 <= heldNext0.tag;
            heldTag1 <= heldNext1.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            heldData0   <= inNext0.data;
            heldData1   <= inNext1.data;
            heldOp      <= dispatch.op;
            heldDestTag <= dispatch.destTag;
            heldName    <= dispatch.destName;
        end else begin
            heldData0 <= heldNext0.data;
            heldData1 <= heldNext1.data;
        end
    end

    // Ready as soon as the forwarded tags are both free.
    assign ready = occupied && (heldNext0.tag.raw == tagFree) && (heldNext1.tag.raw == tagFree);

    always_comb begin
        candidate.valid    = ready;
        candidate.op       = heldOp;
        candidate.value0   = heldNext0.data;
        candidate.value1   = heldNext1.data;
        candidate.destTag  = heldDestTag;
        candidate.destName = heldName;
    end

endmodule

// File: rsPkg.sv
package rsPkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int dataWidth = 32;
    localparam int nameWidth = 5;
    localparam int unitWidth = 2;
    localparam int slotWidth = 3;
    localparam int tagWidth  = unitWidth + slotWidth;

    // Raw tag value of an operand whose data is already present.
    localparam logic [tagWidth-1:0] tagFree = '0;

    // Producer of a tag.
    typedef enum logic [unitWidth-1:0] {
        unitNone = 2'd0,
        unitAlu  = 2'd1,
        unitLs   = 2'd2
    } unit_e;

    typedef struct packed {
        unit_e                unit;
        logic [slotWidth-1:0] slot; // Station slot of the producer.
    } tagField_t;

    // Compared as one word, split when a slot is needed.
    typedef union packed {
        logic [tagWidth-1:0] raw;
        tagField_t           field;
    } rsTag_t;

    typedef enum logic [3:0] {
        opNop,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opSlt  // Signed compare.
    } aluOp_e;

    // ======================================================================
    // Bundles
    // ======================================================================
    typedef struct packed {
        rsTag_t               tag;
        logic [dataWidth-1:0] data;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        aluOp_e               op;
        operand_t             operand0;
        operand_t             operand1;
        rsTag_t               destTag;
        logic [nameWidth-1:0] destName;
    } dispatch_t;

    typedef struct packed {
        logic                 valid;
        aluOp_e               op;
        logic [dataWidth-1:0] value0;
        logic [dataWidth-1:0] value1;
        rsTag_t               destTag;
        logic [nameWidth-1:0] destName;
    } issue_t;

    // Result broadcast, valid for a single cycle.
    typedef struct packed {
        logic                 valid;
        rsTag_t               tag;
        logic [nameWidth-1:0] name;
        logic [dataWidth-1:0] data;
    } cdb_t;

endpackage

// File: tbAluStation.sv
`timescale 1ns/1ps

module tbAluStation import rsPkg::*; ();

    localparam int rsSize    = 8;
    localparam int timeout   = 40;
    localparam int driveSkew = 2;

    logic              clk;
    logic              rst;
    dispatch_t         dispatch;
    cdb_t              lsResult;
    cdb_t              aluResult;
    logic [rsSize-1:0] freeMask;
    logic              stationFree;

    int          errorCount = 0;
    int          checkCount = 0;
    logic [31:0] lcgState   = 32'd59;

    logic [rsSize-1:0]    modelOcc;
    operand_t             modelOpnd0 [rsSize];
    operand_t             modelOpnd1 [rsSize];
    aluOp_e               modelOp    [rsSize];
    rsTag_t               modelDest  [rsSize];
    logic [nameWidth-1:0] modelName  [rsSize];
    cdb_t                 modelIssue; // Result of the issue registered this cycle.
    cdb_t                 modelBus; // Expected ALU broadcast of the current cycle.

    tbClock #(.period(40), .resetCycles(2)) u_clock (.clk(clk), .rst(rst));

    aluStation #(
        .rsSize (rsSize)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .lsResult    (lsResult),
        .aluResult   (aluResult),
        .freeMask    (freeMask),
        .stationFree (stationFree)
    );

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic rsTag_t makeTag(unit_e unit, int slot);
        rsTag_t tag;
        tag.field.unit = unit;
        tag.field.slot = slotWidth'(slot);
        return tag;
    endfunction

    function automatic operand_t valueOperand(logic [dataWidth-1:0] value);
        operand_t opnd;
        opnd.tag.raw = '0;
        opnd.data    = value;
        return opnd;
    endfunction

    function automatic operand_t waitingOperand(rsTag_t tag);
        operand_t opnd;
        opnd.tag  = tag;
        opnd.data = nextRand(); // Junk until captured.
        return opnd;
    endfunction

    function automatic logic [dataWidth-1:0] expectedValue(aluOp_e op,
                                                           logic [dataWidth-1:0] a,
                                                           logic [dataWidth-1:0] b);
        logic [4:0] amount;
        amount = b[4:0];
        case (op)
            opAdd: return a + b;
            opSub: return a + ~b + 32'd1;
            opAnd: return a & b;
            opOr:  return a | b;
            opXor: return a ^ b;
            opSll: return a << amount;
            opSrl: return a >> amount;
            opSlt: begin
                if (a[dataWidth-1] != b[dataWidth-1]) return dataWidth'(a[dataWidth-1]);
                return dataWidth'(a < b); // Same sign.
            end
            default: return '0;
        endcase
    endfunction

    // Capture from either bus with the ALU bus first.
    function automatic operand_t wake(operand_t opnd, cdb_t aluBus, cdb_t lsBus);
        operand_t result;
        result = opnd;
        if (opnd.tag.raw != '0 && aluBus.valid && aluBus.tag.raw == opnd.tag.raw) begin
            result.tag.raw = '0;
            result.data    = aluBus.data;
        end else if (opnd.tag.raw != '0 && lsBus.valid && lsBus.tag.raw == opnd.tag.raw) begin
            result.tag.raw = '0;
            result.data    = lsBus.data;
        end
        return result;
    endfunction

    task automatic checkValue(string name, logic [63:0] got, logic [63:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("mismatch %s: got %0h expected %0h", name, got, expected);
        end
    endtask

    task automatic reportFailure(string what);
        errorCount++;
        $display("%s", what);
    endtask

    task automatic toDriveTime();
        @(posedge clk);
        #driveSkew;
    endtask

    // Presents one dispatch for one edge.
    task automatic driveDispatch(int slot, aluOp_e op, operand_t opnd0, operand_t opnd1);
        logic [31:0] rnd;
        rnd = nextRand();
        dispatch.valid    = 1'b1;
        dispatch.op       = op;
        dispatch.operand0 = opnd0;
        dispatch.operand1 = opnd1;
        dispatch.destTag  = makeTag(unitAlu, slot);
        dispatch.destName = rnd[nameWidth-1:0];
        toDriveTime();
        dispatch.valid = 1'b0;
    endtask

    task automatic broadcastLs(rsTag_t tag, logic [dataWidth-1:0] data);
        lsResult = '{valid: 1'b1, tag: tag, name: '0, data: data};
        toDriveTime();
        lsResult.valid = 1'b0;
    endtask

    // Counts edges until the broadcast of one tag.
    task automatic waitResult(rsTag_t tag, output int edges);
        bit found;
        found = 1'b0;
        edges = 0;
        while (!found && edges < timeout) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            found = aluResult.valid && aluResult.tag.raw == tag.raw;
        end
        if (!found) begin
            reportFailure($sformatf("Timed out waiting for the result of tag %h.", tag.raw));
        end
    endtask

    // ======================================================================
    // Reference model checked and stepped mid-cycle
    // ======================================================================
    always @(negedge clk) begin
        logic [rsSize-1:0] alloc;
        logic [rsSize-1:0] expectMask;
        operand_t          woke0;
        operand_t          woke1;
        cdb_t              nextBus;
        int                freeSlots;
        int                pick;
        int                slot;
        if (rst) begin
            modelOcc   = '0;
            modelIssue = '0;
            modelBus   = '0;
        end else begin
            expectMask = ~modelOcc;
            checkValue("freeMask", 64'(freeMask), 64'(expectMask));
            alloc = '0;
            if (dispatch.valid) alloc[dispatch.destTag.field.slot] = 1'b1;
            freeSlots = 0;
            for (int i = 0; i < rsSize; i++) begin
                if (!(modelOcc[i] || alloc[i])) freeSlots++;
            end
            checkValue("stationFree", 64'(stationFree), 64'(freeSlots >= 2));
            checkValue("aluResult.valid", 64'(aluResult.valid), 64'(modelBus.valid));
            if (modelBus.valid && aluResult.valid) begin
                checkValue("aluResult.tag", 64'(aluResult.tag.raw), 64'(modelBus.tag.raw));
                checkValue("aluResult.name", 64'(aluResult.name), 64'(modelBus.name));
                checkValue("aluResult.data", 64'(aluResult.data), 64'(modelBus.data));
            end

            pick    = -1;
            nextBus = '0;
            for (int i = 0; i < rsSize; i++) begin
                woke0 = wake(modelOpnd0[i], modelBus, lsResult);
                woke1 = wake(modelOpnd1[i], modelBus, lsResult);
                if (pick < 0 && modelOcc[i] && woke0.tag.raw == '0 && woke1.tag.raw == '0) begin
                    pick         = i; // Lowest ready slot.
                    nextBus.valid = 1'b1;
                    nextBus.tag   = modelDest[i];
                    nextBus.name  = modelName[i];
                    nextBus.data  = expectedValue(modelOp[i], woke0.data, woke1.data);
                end
                modelOpnd0[i] = woke0;
                modelOpnd1[i] = woke1;
            end
            if (pick >= 0) modelOcc[pick] = 1'b0;
            if (dispatch.valid) begin
                slot             = int'(dispatch.destTag.field.slot);
                modelOpnd0[slot] = wake(dispatch.operand0, modelBus, lsResult);
                modelOpnd1[slot] = wake(dispatch.operand1, modelBus, lsResult);
                modelOp[slot]    = dispatch.op;
                modelDest[slot]  = dispatch.destTag;
                modelName[slot]  = dispatch.destName;
                modelOcc[slot]   = 1'b1;
            end
            modelBus   = modelIssue;
            modelIssue = nextBus;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        rsTag_t lsTag;
        aluOp_e op;
        int     edges;
        int     waited;
        dispatch = '0;
        lsResult = '0;

        @(negedge clk);
        waited = 0;
        while (rst && waited < timeout) begin
            @(negedge clk);
            waited++;
        end
        if (rst) reportFailure("Reset was never released.");
        checkValue("aluResult.valid", 64'(aluResult.valid), 64'd0);
        checkValue("freeMask", 64'(freeMask), 64'(8'hff));
        checkValue("stationFree", 64'(stationFree), 64'd1);
        toDriveTime();

        op = opAdd;
        for (int k = 0; k < 8; k++) begin
            driveDispatch(k, op, valueOperand(nextRand()), valueOperand(nextRand()));
            waitResult(makeTag(unitAlu, k), edges);
            checkValue("latency", 64'(edges), 64'd2);
            toDriveTime();
            op = op.next();
        end

        lsTag = makeTag(unitLs, 2); // Held until the load result arrives.
        driveDispatch(3, opSub, waitingOperand(lsTag), valueOperand(nextRand()));
        repeat (4) begin
            @(negedge clk);
            checkValue("aluResult.valid", 64'(aluResult.valid), 64'd0);
        end
        toDriveTime();
        broadcastLs(lsTag, nextRand());
        waitResult(makeTag(unitAlu, 3), edges);
        checkValue("wakeup latency", 64'(edges), 64'd1);
        toDriveTime();

        // Chain through the ALU feedback bus where slot 3 catches it at dispatch.
        driveDispatch(0, opAdd, valueOperand(nextRand()), valueOperand(nextRand()));
        driveDispatch(1, opSub, waitingOperand(makeTag(unitAlu, 0)), valueOperand(nextRand()));
        driveDispatch(2, opXor, waitingOperand(makeTag(unitAlu, 1)),
                      waitingOperand(makeTag(unitAlu, 0)));
        driveDispatch(3, opSll, waitingOperand(makeTag(unitAlu, 0)), valueOperand(nextRand()));
        waitResult(makeTag(unitAlu, 2), edges);
        toDriveTime();

        lsTag    = makeTag(unitLs, 5);
        lsResult = '{valid: 1'b1, tag: lsTag, name: '0, data: nextRand()};
        driveDispatch(4, opOr, valueOperand(nextRand()), waitingOperand(lsTag));
        lsResult.valid = 1'b0;
        waitResult(makeTag(unitAlu, 4), edges);
        checkValue("latency", 64'(edges), 64'd2);
        toDriveTime();

        lsTag = makeTag(unitLs, 1);
        op    = opAdd;
        for (int s = 0; s < rsSize; s++) begin
            driveDispatch(s, op, waitingOperand(lsTag), valueOperand(nextRand()));
            op = (op == opSlt) ? opAdd : op.next();
        end
        @(negedge clk);
        checkValue("freeMask", 64'(freeMask), 64'd0);
        checkValue("stationFree", 64'(stationFree), 64'd0);
        toDriveTime();
        broadcastLs(lsTag, nextRand());
        waitResult(makeTag(unitAlu, 0), edges);
        for (int s = 1; s < rsSize; s++) begin
            @(negedge clk);
            checkValue("aluResult.valid", 64'(aluResult.valid), 64'd1);
            checkValue("aluResult.tag", 64'(aluResult.tag.raw), 64'(makeTag(unitAlu, s)));
        end
        repeat (3) @(negedge clk);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int period      = 40,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2 rst = 1'b0; // Released just after the last reset edge.
    end

endmodule

// File: wakeupMux.sv
`timescale 1ns/1ps

module wakeupMux import rsPkg::*; (
    input  cdb_t     aluBus,
    input  cdb_t     lsBus,
    input  operand_t now,
    output operand_t next
);

    logic waiting;
    logic aluHit;
    logic lsHit;

    assign waiting = now.tag.raw != tagFree;
    assign aluHit  = waiting && aluBus.valid && (aluBus.tag.raw == now.tag.raw);
    assign lsHit   = waiting && lsBus.valid && (lsBus.tag.raw == now.tag.raw);

    always_comb begin
        next = now;
        if (aluHit) begin // ALU bus wins a double match.
            next.tag.raw = tagFree;
            next.data    = aluBus.data;
        end else if (lsHit) begin
            next.tag.raw = tagFree;
            next.data    = lsBus.data;
        end
    end

endmodule
